//--- verilog/l1_dcache_defs.svh
`ifndef L1_DCACHE_DEFS_SVH
`define L1_DCACHE_DEFS_SVH

// cache geometry, 64 sets of one 64-byte line each
`define L1_SETS 64
`define L1_INDEX_BITS 6

// byte offset within a line
`define L1_OFFSET_BITS 6
`define L1_TAG_BITS 20

`define L1_LINE_BITS 512
`define L1_WORDS 16
`define L1_WORD_BITS 32

`endif

//--- verilog/l1_dcache_pkg.sv
`default_nettype none
`include "l1_dcache_defs.svh"

package l1_dcache_pkg;

        // tag | index | word select | byte offset
        typedef struct packed {
                logic [`L1_TAG_BITS-1:0] tag;
                logic [`L1_INDEX_BITS-1:0] index;
                logic [`L1_OFFSET_BITS-3:0] word_sel;
                logic [1:0] byte_off;
        } l1_addr_s;

        typedef union packed {
                logic [`L1_WORD_BITS-1:0] raw;
                l1_addr_s f;
        } l1_addr_u;

        typedef enum logic [2:0] {
                IDLE, LOOKUP, READ_OUT, REFILL_REQ,
                REFILL_DONE, WRITE_REQ, WRITE_DONE, RESPOND
        } l1_state_e;

endpackage

`default_nettype wire

//--- verilog/l1_array_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "l1_dcache_defs.svh"

interface l1_array_if;
        logic [`L1_INDEX_BITS-1:0] index;
        logic [`L1_OFFSET_BITS-3:0] word_sel;
        logic [`L1_TAG_BITS-1:0] lookup_tag;

        // single-cycle write strobes
        logic refill;
        logic update;

        logic [`L1_LINE_BITS-1:0] line_in;
        logic [`L1_WORD_BITS-1:0] word_in;
        logic [`L1_WORD_BITS-1:0] word_out;
        logic hit;

        modport ctrl (output index, word_sel, lookup_tag, refill, update, line_in, word_in,
                      input word_out, hit);

        modport data (input index, word_sel, refill, update, line_in, word_in,
                      output word_out);

        modport tag (input index, lookup_tag, refill,
                     output hit);
endinterface

`default_nettype wire

//--- verilog/l1_d_data_array.sv
`timescale 1ns/100ps
`default_nettype none
`include "l1_dcache_defs.svh"

module l1_d_data_array (
        input wire logic clk,
        input wire logic nrst,
        l1_array_if.data arr
);

        // each line is kept as 16 words so an update can address one word directly
        logic [`L1_WORDS-1:0][`L1_WORD_BITS-1:0] mem [`L1_SETS];

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        for (int i = 0; i < `L1_SETS; i++)
                        begin
                                mem[i] <= '0;
                        end
                end
                else if (arr.refill)
                begin
                        mem[arr.index] <= arr.line_in;
                end
                else if (arr.update)
                begin
                        mem[arr.index][arr.word_sel] <= arr.word_in;
                end
        end

        // the read sees the array before this edge's write, so new data shows one cycle later
        always_ff @(posedge clk)
        begin
                arr.word_out <= mem[arr.index][arr.word_sel];
        end

        // the controller only issues one kind of write per access
        a_no_refill_and_update: assert property (@(posedge clk) disable iff (!nrst)
                !(arr.refill && arr.update));

endmodule

`default_nettype wire

//--- verilog/l1_d_tag_array.sv
`timescale 1ns/100ps
`default_nettype none
`include "l1_dcache_defs.svh"

module l1_d_tag_array (
        input wire logic clk,
        input wire logic nrst,
        l1_array_if.tag arr
);

        logic [`L1_SETS-1:0] valid;
        logic [`L1_TAG_BITS-1:0] tags [`L1_SETS];

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        valid <= '0;
                end
                else if (arr.refill)
                begin
                        valid[arr.index] <= 1'b1;
                end
        end

        // stale tags are harmless while the valid bit is clear
        always_ff @(posedge clk)
        begin
                if (arr.refill)
                begin
                        tags[arr.index] <= arr.lookup_tag;
                end
        end

        assign arr.hit = valid[arr.index] && (tags[arr.index] == arr.lookup_tag);

        // a refilled line must hit on the lookup that follows it
        a_hit_after_refill: assert property (@(posedge clk) disable iff (!nrst)
                arr.refill |=> (arr.hit || !$stable(arr.index) || !$stable(arr.lookup_tag)));

endmodule

`default_nettype wire

//--- verilog/l1_d_controller.sv
`timescale 1ns/100ps
`default_nettype none
`include "l1_dcache_defs.svh"

module l1_d_controller (
        input wire logic clk,
        input wire logic nrst,

        input wire logic cpu_req,
        input wire logic cpu_we,
        input wire l1_dcache_pkg::l1_addr_u cpu_addr,
        input wire logic [`L1_WORD_BITS-1:0] cpu_wdata,
        output logic cpu_ack,
        output logic [`L1_WORD_BITS-1:0] cpu_rdata,

        output logic l2_req,
        output logic l2_we,
        output logic [`L1_WORD_BITS-1:0] l2_addr,
        output logic [`L1_WORD_BITS-1:0] l2_wdata,
        input wire logic l2_ack,
        input wire logic [`L1_LINE_BITS-1:0] l2_rdata,

        l1_array_if.ctrl arr
);
        import l1_dcache_pkg::*;

        l1_state_e state;
        l1_addr_u req_addr;
        logic req_we;
        logic [`L1_WORD_BITS-1:0] req_wdata;

        // request fields are held from IDLE until the next request
        always_ff @(posedge clk)
        begin
                if (state == IDLE && cpu_req)
                begin
                        req_addr <= cpu_addr;
                        req_we <= cpu_we;
                        req_wdata <= cpu_wdata;
                end
                if (state == READ_OUT)
                begin
                        cpu_rdata <= arr.word_out;
                end
        end

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        state <= IDLE;
                        cpu_ack <= 1'b0;
                        l2_req <= 1'b0;
                        l2_we <= 1'b0;
                end
                else
                begin
                        case (state)
                        IDLE:
                                if (cpu_req)
                                        state <= LOOKUP;
                        LOOKUP:
                                if (req_we)
                                begin
                                        state <= WRITE_REQ;
                                        l2_req <= 1'b1;
                                        l2_we <= 1'b1;
                                end
                                else if (arr.hit)
                                begin
                                        state <= READ_OUT;
                                end
                                else
                                begin
                                        state <= REFILL_REQ;
                                        l2_req <= 1'b1;
                                end
                        READ_OUT:
                        begin
                                state <= RESPOND;
                                cpu_ack <= 1'b1;
                        end
                        REFILL_REQ:
                                if (l2_ack)
                                begin
                                        state <= REFILL_DONE;
                                        l2_req <= 1'b0;
                                end
                        // the refilled line goes back through LOOKUP and is read as a hit
                        REFILL_DONE:
                                if (!l2_ack)
                                        state <= LOOKUP;
                        WRITE_REQ:
                                if (l2_ack)
                                begin
                                        state <= WRITE_DONE;
                                        l2_req <= 1'b0;
                                        l2_we <= 1'b0;
                                end
                        WRITE_DONE:
                                if (!l2_ack)
                                begin
                                        state <= RESPOND;
                                        cpu_ack <= 1'b1;
                                end
                        RESPOND:
                                if (!cpu_req)
                                begin
                                        state <= IDLE;
                                        cpu_ack <= 1'b0;
                                end
                        default:
                                state <= IDLE;
                        endcase
                end
        end

        assign arr.index = req_addr.f.index;
        assign arr.word_sel = req_addr.f.word_sel;
        assign arr.lookup_tag = req_addr.f.tag;
        assign arr.line_in = l2_rdata;
        assign arr.word_in = req_wdata;

        // the line is written on the first cycle the L2 ack is seen
        assign arr.refill = (state == REFILL_REQ) && l2_ack;
        assign arr.update = (state == LOOKUP) && req_we && arr.hit;

        // refills fetch the whole line, writes go out at the word address
        assign l2_addr = req_we ? req_addr.raw
                                : {req_addr.f.tag, req_addr.f.index, {`L1_OFFSET_BITS{1'b0}}};
        assign l2_wdata = req_wdata;

        a_cpu_addr_stable: assert property (@(posedge clk) disable iff (!nrst)
                (cpu_req && !cpu_ack) |=> $stable(cpu_addr.raw));

        a_l2_req_held: assert property (@(posedge clk) disable iff (!nrst)
                (l2_req && !l2_ack) |=> l2_req);

endmodule

`default_nettype wire

//--- verilog/l1_dcache.sv
`timescale 1ns/100ps
`default_nettype none
`include "l1_dcache_defs.svh"

module l1_dcache (
        input wire logic clk,
        input wire logic nrst,

        input wire logic cpu_req,
        input wire logic cpu_we,
        input wire l1_dcache_pkg::l1_addr_u cpu_addr,
        input wire logic [`L1_WORD_BITS-1:0] cpu_wdata,
        output wire logic cpu_ack,
        output wire logic [`L1_WORD_BITS-1:0] cpu_rdata,

        output wire logic l2_req,
        output wire logic l2_we,
        output wire logic [`L1_WORD_BITS-1:0] l2_addr,
        output wire logic [`L1_WORD_BITS-1:0] l2_wdata,
        input wire logic l2_ack,
        input wire logic [`L1_LINE_BITS-1:0] l2_rdata
);

        l1_array_if arr ();

        l1_d_controller u_ctrl (
                .clk (clk),
                .nrst (nrst),
                .cpu_req (cpu_req),
                .cpu_we (cpu_we),
                .cpu_addr (cpu_addr),
                .cpu_wdata (cpu_wdata),
                .cpu_ack (cpu_ack),
                .cpu_rdata (cpu_rdata),
                .l2_req (l2_req),
                .l2_we (l2_we),
                .l2_addr (l2_addr),
                .l2_wdata (l2_wdata),
                .l2_ack (l2_ack),
                .l2_rdata (l2_rdata),
                .arr (arr.ctrl)
        );

        l1_d_data_array u_data (.clk(clk), .nrst(nrst), .arr(arr.data));

        l1_d_tag_array u_tag (.clk(clk), .nrst(nrst), .arr(arr.tag));

endmodule

`default_nettype wire

//--- verif/l2_memory_model.sv
`timescale 1ns/100ps
`default_nettype none
`include "l1_dcache_defs.svh"

module l2_memory_model (
        input wire logic clk,
        input wire logic nrst,
        input wire logic l2_req,
        input wire logic l2_we,
        input wire logic [31:0] l2_addr,
        input wire logic [31:0] l2_wdata,
        output logic l2_ack,
        output logic [`L1_LINE_BITS-1:0] l2_rdata,
        output int refill_count,
        output int write_count,
        output logic [31:0] last_wr_addr,
        output logic [31:0] last_wr_data
);

        logic [31:0] seed;
        int delay;
        logic [31:0] written [logic [31:0]];

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1103515245 + 32'd12345;
        endfunction

        // written words override the address pattern
        function automatic logic [31:0] stored_word(input logic [31:0] addr);
                logic [31:0] a;
                a = {addr[31:2], 2'b00};
                if (written.exists(a))
                        return written[a];
                return a ^ 32'h5a5a0000;
        endfunction

        initial
        begin
                seed = 32'h316e;
                l2_ack = 1'b0;
                l2_rdata = '0;
                refill_count = 0;
                write_count = 0;
                last_wr_addr = '0;
                last_wr_data = '0;
        end

        // responds on the falling edge, after a random wait of 0 to 7 cycles
        always
        begin
                @(negedge clk);
                if (nrst && l2_req && !l2_ack)
                begin
                        seed = lcg_next(seed);
                        delay = int'(seed[18:16]);
                        repeat (delay) @(negedge clk);
                        if (l2_we)
                        begin
                                written[{l2_addr[31:2], 2'b00}] = l2_wdata;
                                last_wr_addr = l2_addr;
                                last_wr_data = l2_wdata;
                                write_count++;
                        end
                        else
                        begin
                                // the line starts at the requested address as given
                                for (int k = 0; k < `L1_WORDS; k++)
                                begin
                                        l2_rdata[k*32 +: 32] = stored_word(l2_addr + k * 4);
                                end
                                refill_count++;
                        end
                        l2_ack = 1'b1;
                        while (l2_req)
                                @(negedge clk);
                        l2_ack = 1'b0;
                end
        end

endmodule

`default_nettype wire

//--- verif/tb_l1_dcache.sv
`timescale 1ns/100ps
`default_nettype none
`include "l1_dcache_defs.svh"

module tb_l1_dcache;
        import l1_dcache_pkg::*;

        localparam int NUM_ROWS = 12;
        localparam int RESET_CYCLES = 3;
        localparam int MAX_CYCLES = NUM_ROWS * 64 + RESET_CYCLES;

        logic clk = 1'b0;
        logic nrst;
        logic cpu_req;
        logic cpu_we;
        l1_addr_u cpu_addr;
        logic [31:0] cpu_wdata;
        logic cpu_ack;
        logic [31:0] cpu_rdata;
        logic l2_req;
        logic l2_we;
        logic [31:0] l2_addr;
        logic [31:0] l2_wdata;
        logic l2_ack;
        logic [`L1_LINE_BITS-1:0] l2_rdata;
        int refill_count;
        int write_count;
        logic [31:0] last_wr_addr;
        logic [31:0] last_wr_data;

        logic row_we [NUM_ROWS];
        l1_addr_u row_addr [NUM_ROWS];
        logic [31:0] row_wdata [NUM_ROWS];
        logic [31:0] row_rdata [NUM_ROWS];
        int row_refills [NUM_ROWS];
        logic [31:0] shadow [logic [31:0]];
        int rows_built;
        int errors;
        int failed_tests;
        int cycles = 0;

        always #4 clk = ~clk;

        l1_dcache dut (
                .clk (clk), .nrst (nrst),
                .cpu_req (cpu_req), .cpu_we (cpu_we), .cpu_addr (cpu_addr),
                .cpu_wdata (cpu_wdata), .cpu_ack (cpu_ack), .cpu_rdata (cpu_rdata),
                .l2_req (l2_req), .l2_we (l2_we), .l2_addr (l2_addr),
                .l2_wdata (l2_wdata), .l2_ack (l2_ack), .l2_rdata (l2_rdata)
        );

        l2_memory_model u_l2 (
                .clk (clk), .nrst (nrst),
                .l2_req (l2_req), .l2_we (l2_we), .l2_addr (l2_addr),
                .l2_wdata (l2_wdata), .l2_ack (l2_ack), .l2_rdata (l2_rdata),
                .refill_count (refill_count), .write_count (write_count),
                .last_wr_addr (last_wr_addr), .last_wr_data (last_wr_data)
        );

        // what L2 holds at a word address, tracked independently of the model
        function automatic logic [31:0] l2_word(input logic [31:0] addr);
                if (shadow.exists(addr))
                        return shadow[addr];
                return addr ^ 32'h5a5a0000;
        endfunction

        task automatic add_row(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                               input int refills);
                row_we[rows_built] = we;
                row_addr[rows_built].raw = addr;
                row_wdata[rows_built] = wdata;
                if (we)
                        shadow[addr] = wdata;
                row_rdata[rows_built] = we ? 32'h0 : l2_word(addr);
                row_refills[rows_built] = refills;
                rows_built++;
        endtask

        task automatic run_row(input int r);
                int writes_before;
                int errors_before;
                writes_before = write_count;
                errors_before = errors;
                @(negedge clk);
                cpu_req = 1'b1;
                cpu_we = row_we[r];
                cpu_addr = row_addr[r];
                cpu_wdata = row_wdata[r];
                while (!cpu_ack)
                        @(negedge clk);
                // both L2 phases must be over by the time the processor sees its ack
                assert (!l2_req && !l2_ack) else
                begin
                        $display("row %0d: cpu_ack rose before the L2 handshake finished", r);
                        errors++;
                end
                assert (refill_count == row_refills[r]) else
                begin
                        $display("Mismatch row %0d refill_count: got %h, expected %h",
                                 r, refill_count, row_refills[r]);
                        errors++;
                end
                if (row_we[r])
                begin
                        assert (write_count == writes_before + 1) else
                        begin
                                $display("row %0d: the write did not reach L2 exactly once", r);
                                errors++;
                        end
                        assert (last_wr_addr == row_addr[r].raw) else
                        begin
                                $display("Mismatch row %0d l2_addr: got %h, expected %h",
                                         r, last_wr_addr, row_addr[r].raw);
                                errors++;
                        end
                        assert (last_wr_data == row_wdata[r]) else
                        begin
                                $display("Mismatch row %0d l2_wdata: got %h, expected %h",
                                         r, last_wr_data, row_wdata[r]);
                                errors++;
                        end
                end
                else
                begin
                        assert (write_count == writes_before) else
                        begin
                                $display("row %0d: a read sent a write to L2", r);
                                errors++;
                        end
                        assert (cpu_rdata == row_rdata[r]) else
                        begin
                                $display("Mismatch row %0d cpu_rdata: got %h, expected %h",
                                         r, cpu_rdata, row_rdata[r]);
                                errors++;
                        end
                end
                cpu_req = 1'b0;
                @(negedge clk);
                while (cpu_ack)
                        @(negedge clk);
                if (errors != errors_before)
                        failed_tests++;
                $display("row %0d %s %h index %0d: %s", r, row_we[r] ? "write" : "read ",
                         row_addr[r].raw, row_addr[r].f.index,
                         (errors == errors_before) ? "ok" : "FAILED");
        endtask

        initial
        begin
                nrst = 1'b0;
                cpu_req = 1'b0;
                cpu_we = 1'b0;
                cpu_addr = '0;
                cpu_wdata = '0;
                errors = 0;
                failed_tests = 0;
                rows_built = 0;

                // index 1 holds tag 1 first, then tag 0x55 evicts it
                add_row(1'b0, 32'h0000_1040, 32'h0, 1);
                add_row(1'b0, 32'h0000_1064, 32'h0, 1);
                add_row(1'b1, 32'h0000_1048, 32'hdead_beef, 1);
                add_row(1'b0, 32'h0000_1048, 32'h0, 1);
                add_row(1'b1, 32'h0002_3080, 32'h1234_5678, 1);
                add_row(1'b0, 32'h0002_3080, 32'h0, 2);
                add_row(1'b0, 32'h0005_5040, 32'h0, 3);
                add_row(1'b0, 32'h0000_1048, 32'h0, 4);
                // a write miss on index 1 must leave the cached word at the same offset alone
                add_row(1'b1, 32'h0007_7064, 32'h0bad_0bad, 4);
                add_row(1'b0, 32'h0000_1064, 32'h0, 4);
                add_row(1'b1, 32'h0000_1050, 32'hcafe_f00d, 4);
                add_row(1'b0, 32'h0000_1050, 32'h0, 4);

                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                nrst = 1'b1;
                @(negedge clk);
                assert (!cpu_ack && !l2_req) else
                begin
                        $display("cpu_ack or l2_req is high right after reset");
                        errors++;
                end

                for (int r = 0; r < NUM_ROWS; r++)
                        run_row(r);

                $display("%0d tests, %0d failed, %0d errors", NUM_ROWS, failed_tests, errors);
                if (errors == 0)
                        $display("Test passed");
                else
                        $display("Test failed");
                $finish;
        end

        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES)
                begin
                        $display("timeout after %0d cycles, controller stuck in state %s",
                                 cycles, dut.u_ctrl.state.name());
                        $display("Test failed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- l1_dcache.f
+incdir+verilog
verilog/l1_dcache_pkg.sv
verilog/l1_array_if.sv
verilog/l1_d_data_array.sv
verilog/l1_d_tag_array.sv
verilog/l1_d_controller.sv
verilog/l1_dcache.sv
verif/l2_memory_model.sv
verif/tb_l1_dcache.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP = tb_l1_dcache
RTL_TOP = l1_dcache
FILELIST = l1_dcache.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Test passed$$"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
